/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := btb_bht_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard hw/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'RESULT: PASS'

clean:
	rm -rf $(OBJ_DIR)

/* hw/btb_alloc.sv */
`default_nettype none
`timescale 1ns/1ps

`include "btb_cfg.svh"

// picks the entry that a replace writes
// an entry already holding the tag wins over the round-robin pointer
module btb_alloc (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    replace,   // install request from mem stage
  input  logic [`BTB_ENTRIES-1:0] mem_match, // valid entries whose tag equals mem_pc
  output logic [`BTB_ENTRIES-1:0] entry_write
);

  logic [`BTB_INDEX_BITS-1:0] ptr;        // next victim in round-robin order
  logic [`BTB_ENTRIES-1:0]    ptr_onehot;
  logic                       any_match;

  assign any_match = |mem_match; // at most one bit, tags are never duplicated

  // decode the pointer into a one-hot entry select
  always_comb begin
    ptr_onehot      = '0;
    ptr_onehot[ptr] = 1'b1;
  end

  // reinstalling a known tag rewrites that entry in place
  always_comb begin
    if (!replace) begin
      entry_write = '0;
    end else if (any_match) begin
      entry_write = mem_match;
    end else begin
      entry_write = ptr_onehot;
    end
  end

  // pointer moves only when a fresh entry was consumed
  // entry count is a power of two, so the add wraps by itself
  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
    end else if (replace && !any_match) begin
      ptr <= ptr + `BTB_INDEX_BITS'(1);
    end
  end

endmodule

`default_nettype wire

/* hw/btb_bht.sv */
`default_nettype none
`timescale 1ns/1ps

`include "btb_cfg.svh"

// branch target buffer with per-entry two-bit history counters
// fetch looks up combinationally, the mem stage installs and trains
module btb_bht (
  input  logic                       clk,
  input  logic                       rst,
  input  rv32i_types_pkg::rv32i_word if_pc,         // fetch pc for lookup
  input  rv32i_types_pkg::rv32i_word mem_pc,        // pc of the branch in mem
  input  rv32i_types_pkg::rv32i_word target_in,     // resolved target to install
  input  logic                       replace,       // install mem_pc and target_in
  input  logic                       branch_result, // resolved outcome, 1 = taken
  input  logic                       update,        // train the counter for mem_pc
  output logic                       hit,
  output rv32i_types_pkg::rv32i_word target_out,
  output logic                       prediction
);

  import rv32i_types_pkg::*;

  logic [`BTB_ENTRIES-1:0] entry_write;
  logic [`BTB_ENTRIES-1:0] mem_match;
  logic [`BTB_ENTRIES-1:0] if_match;
  logic [`BTB_ENTRIES-1:0] entry_taken;
  rv32i_word               entry_target [`BTB_ENTRIES];

  btb_alloc alloc0 (
    .clk         (clk),
    .rst         (rst),
    .replace     (replace),
    .mem_match   (mem_match),
    .entry_write (entry_write)
  );

  // storage, one entry per slot, mem side inputs shared by all
  for (genvar i = 0; i < `BTB_ENTRIES; i++) begin : gen_entry
    btb_entry entry (
      .clk           (clk),
      .rst           (rst),
      .write         (entry_write[i]),
      .update        (update),
      .branch_result (branch_result),
      .if_pc         (if_pc),
      .mem_pc        (mem_pc),
      .target_in     (target_in),
      .if_match      (if_match[i]),
      .mem_match     (mem_match[i]),
      .taken         (entry_taken[i]),
      .target        (entry_target[i])
    );
  end

  btb_select select0 (
    .if_match     (if_match),
    .entry_taken  (entry_taken),
    .entry_target (entry_target),
    .hit          (hit),
    .prediction   (prediction),
    .target_out   (target_out)
  );

endmodule

`default_nettype wire

/* hw/btb_cfg.svh */
`ifndef BTB_CFG_SVH
`define BTB_CFG_SVH

// log2 of the number of buffer entries
`define BTB_INDEX_BITS 4

// number of buffer entries
`define BTB_ENTRIES (1 << `BTB_INDEX_BITS)

// counter state loaded on install, weakly not taken
`define BTB_CTR_INIT 2'b01

`endif

/* hw/btb_entry.sv */
`default_nettype none
`timescale 1ns/1ps

`include "btb_cfg.svh"

// a single fully associative buffer entry
// holds one tag, its target and a two-bit history counter
module btb_entry (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       write,         // install strobe from the allocator
  input  logic                       update,        // counter training strobe, broadcast
  input  logic                       branch_result, // actual outcome, 1 = taken
  input  rv32i_types_pkg::rv32i_word if_pc,
  input  rv32i_types_pkg::rv32i_word mem_pc,
  input  rv32i_types_pkg::rv32i_word target_in,
  output logic                       if_match,
  output logic                       mem_match,
  output logic                       taken,
  output rv32i_types_pkg::rv32i_word target
);

  import rv32i_types_pkg::*;

  rv32i_word tag;
  logic      valid;
  bht_state  ctr;
  bht_state  ctr_next;

  // tag compares for the fetch lookup and the mem stage write side
  assign if_match  = valid && (tag == if_pc);
  assign mem_match = valid && (tag == mem_pc);

  assign taken = ctr[1]; // upper counter bit is the prediction

  // saturating step toward the observed outcome
  always_comb begin
    ctr_next = ctr;
    if (branch_result) begin
      if (ctr != bht_strong_t) begin
        ctr_next = bht_state'(ctr + 2'd1);
      end
    end else begin
      if (ctr != bht_strong_nt) begin
        ctr_next = bht_state'(ctr - 2'd1);
      end
    end
  end

  // valid and counter, an install takes priority over training
  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
      ctr   <= bht_state'(`BTB_CTR_INIT);
    end else if (write) begin
      valid <= 1'b1;
      ctr   <= bht_state'(`BTB_CTR_INIT); // fresh or refreshed entry starts weakly not taken
    end else if (update && mem_match) begin
      ctr <= ctr_next;
    end
  end

  // tag and target payload
  always_ff @(posedge clk) begin
    if (write) begin
      tag    <= mem_pc;
      target <= target_in;
    end
  end

endmodule

`default_nettype wire

/* hw/btb_select.sv */
`default_nettype none
`timescale 1ns/1ps

`include "btb_cfg.svh"

// folds the per-entry results into the fetch outputs
// relies on at most one entry matching the fetch pc
module btb_select (
  input  logic [`BTB_ENTRIES-1:0]    if_match,
  input  logic [`BTB_ENTRIES-1:0]    entry_taken,
  input  rv32i_types_pkg::rv32i_word entry_target [`BTB_ENTRIES],
  output logic                       hit,
  output logic                       prediction,
  output rv32i_types_pkg::rv32i_word target_out
);

  localparam int WORD_BITS = $bits(target_out);

  assign hit = |if_match;

  // a miss leaves prediction low
  assign prediction = |(if_match & entry_taken);

  // masked or of all targets, zero on a miss
  always_comb begin
    target_out = '0;
    for (int i = 0; i < `BTB_ENTRIES; i++) begin
      target_out = target_out | (entry_target[i] & {WORD_BITS{if_match[i]}});
    end
  end

endmodule

`default_nettype wire

/* hw/rv32i_types_pkg.sv */
`default_nettype none

// shared word and counter types for the rv32i fetch side predictors
package rv32i_types_pkg;

  // instruction address, tag or branch target
  typedef logic [31:0] rv32i_word;

  // two-bit saturating branch history counter
  // the upper bit gives the taken prediction
  typedef enum logic [1:0] {
    bht_strong_nt = 2'b00, // strongly not taken
    bht_weak_nt   = 2'b01, // weakly not taken
    bht_weak_t    = 2'b10, // weakly taken
    bht_strong_t  = 2'b11  // strongly taken
  } bht_state;

endpackage

`default_nettype wire

/* list.f */
+incdir+hw
hw/rv32i_types_pkg.sv
hw/btb_alloc.sv
hw/btb_entry.sv
hw/btb_select.sv
hw/btb_bht.sv
test/btb_bht_props.sv
test/btb_bht_tb.sv

/* test/btb_bht_props.sv */
`default_nettype none
`timescale 1ns/1ps

`include "btb_cfg.svh"

// checks on the match vectors and the allocator write strobe
module btb_bht_props (
  input logic                    clk,
  input logic                    rst,
  input logic                    replace,
  input logic                    hit,
  input logic [`BTB_ENTRIES-1:0] if_match,
  input logic [`BTB_ENTRIES-1:0] mem_match,
  input logic [`BTB_ENTRIES-1:0] entry_write
);

  fetch_match_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(if_match))
    else $error("fetch pc matched more than one entry");

  mem_match_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(mem_match))
    else $error("mem pc matched more than one entry");

  // a replace writes exactly one entry
  write_onehot: assert property (@(posedge clk) disable iff (rst)
    replace |-> $onehot(entry_write))
    else $error("replace did not select exactly one entry");

  write_idle: assert property (@(posedge clk) disable iff (rst)
    !replace |-> (entry_write == '0))
    else $error("entry write strobe without replace");

  reset_clears_hit: assert property (@(posedge clk)
    rst |=> !hit)
    else $error("hit set in the cycle after reset");

endmodule

bind btb_bht btb_bht_props props0 (
  .clk         (clk),
  .rst         (rst),
  .replace     (replace),
  .hit         (hit),
  .if_match    (if_match),
  .mem_match   (mem_match),
  .entry_write (entry_write)
);

`default_nettype wire

/* test/btb_bht_tb.sv */
`default_nettype none
`timescale 1ns/1ps

`include "btb_cfg.svh"

module btb_bht_tb;

  import rv32i_types_pkg::*;

  localparam int       POOL_SIZE       = 24;  // pool larger than the buffer to force evictions
  localparam int       RANDOM_CYCLES   = 600;
  localparam int       DIRECTED_CYCLES = 400; // generous bound on resets and directed tests
  localparam int       CYCLE_LIMIT     = 2 * (RANDOM_CYCLES + DIRECTED_CYCLES);
  localparam bht_state CTR_INIT        = bht_state'(`BTB_CTR_INIT);

  // training sequence with bit i as step i
  localparam logic [7:0] TRAIN_OUTCOME = 8'b0011_1100; // nt nt t t t t nt nt
  localparam logic [7:0] TRAIN_PRED    = 8'b0111_1000; // prediction after each step

  logic      clk = 1'b0;
  logic      rst;
  rv32i_word if_pc;
  rv32i_word mem_pc;
  rv32i_word target_in;
  logic      replace;
  logic      branch_result;
  logic      update;
  logic      hit;
  rv32i_word target_out;
  logic      prediction;

  // directed expectation checked at the next falling edge
  logic      dir_valid;
  logic      dir_hit;
  rv32i_word dir_target;
  logic      dir_pred;

  // reference model of the buffer
  rv32i_word ref_tag    [`BTB_ENTRIES];
  logic      ref_valid  [`BTB_ENTRIES] = '{default: 1'b0};
  rv32i_word ref_target [`BTB_ENTRIES];
  bht_state  ref_ctr    [`BTB_ENTRIES];
  int        ref_ptr     = 0;
  logic      model_ready = 1'b0;

  integer    seed          = 94;
  int        error_count   = 0;
  int        pass_count    = 0;
  int        test_err_base = 0;
  int        cycle_count   = 0;
  rv32i_word fill_target [POOL_SIZE];

  btb_bht dut0 (
    .clk           (clk),
    .rst           (rst),
    .if_pc         (if_pc),
    .mem_pc        (mem_pc),
    .target_in     (target_in),
    .replace       (replace),
    .branch_result (branch_result),
    .update        (update),
    .hit           (hit),
    .target_out    (target_out),
    .prediction    (prediction)
  );

  always #20 clk = ~clk; // 40 ns period

  always @(posedge clk) begin : watchdog
    cycle_count = cycle_count + 1;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("timeout: the tests did not finish within %0d clock cycles", CYCLE_LIMIT);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  function automatic rv32i_word pool_pc(input int idx);
    return 32'h0000_4000 + (rv32i_word'(idx) << 2); // word aligned pcs
  endfunction

  function automatic int random_index(input int n);
    return ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  function automatic rv32i_word random_aligned();
    rv32i_word r;
    r = $random(seed);
    return {r[31:2], 2'b00};
  endfunction

  // counter transitions saturating at both ends
  function automatic bht_state next_counter(input bht_state s, input logic taken);
    case (s)
      bht_strong_nt: return taken ? bht_weak_nt  : bht_strong_nt;
      bht_weak_nt:   return taken ? bht_weak_t   : bht_strong_nt;
      bht_weak_t:    return taken ? bht_strong_t : bht_weak_nt;
      default:       return taken ? bht_strong_t : bht_weak_t;
    endcase
  endfunction

  function automatic int find_model_entry(input rv32i_word pc);
    for (int i = 0; i < `BTB_ENTRIES; i++) begin
      if (ref_valid[i] && ref_tag[i] == pc) begin
        return i;
      end
    end
    return -1;
  endfunction

  function automatic void ref_lookup(input rv32i_word pc, output logic exp_hit,
                                     output rv32i_word exp_target, output logic exp_pred);
    int idx;
    idx        = find_model_entry(pc);
    exp_hit    = 1'b0;
    exp_target = '0;
    exp_pred   = 1'b0;
    if (idx >= 0) begin
      exp_hit    = 1'b1;
      exp_target = ref_target[idx];
      exp_pred   = (ref_ctr[idx] == bht_weak_t) || (ref_ctr[idx] == bht_strong_t);
    end
  endfunction

  // model follows the strobes sampled at each rising edge
  always @(posedge clk) begin : model_update
    int idx;
    idx = find_model_entry(mem_pc);
    if (rst) begin
      for (int i = 0; i < `BTB_ENTRIES; i++) begin
        ref_valid[i] = 1'b0;
      end
      ref_ptr     = 0;
      model_ready = 1'b1;
    end else if (replace) begin
      if (idx < 0) begin
        idx     = ref_ptr; // no copy of the tag so the round-robin victim is taken
        ref_ptr = (ref_ptr + 1) % `BTB_ENTRIES;
      end
      ref_valid[idx]  = 1'b1;
      ref_tag[idx]    = mem_pc;
      ref_target[idx] = target_in;
      ref_ctr[idx]    = CTR_INIT; // install wins over a same-cycle update
    end else if (update && idx >= 0) begin
      ref_ctr[idx] = next_counter(ref_ctr[idx], branch_result);
    end
  end

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("MISMATCH time=%0t signal=%s got=%b expected=%b", $time, name, actual, expected);
      error_count = error_count + 1;
    end else begin
      pass_count = pass_count + 1;
    end
  endtask

  task automatic check_word(input string name, input rv32i_word actual,
                            input rv32i_word expected);
    if (actual !== expected) begin
      $display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, name, actual, expected);
      error_count = error_count + 1;
    end else begin
      pass_count = pass_count + 1;
    end
  endtask

  // outputs compared before the new stimulus of this edge takes effect
  always @(negedge clk) begin : compare_outputs
    logic      exp_hit;
    rv32i_word exp_target;
    logic      exp_pred;
    if (model_ready) begin
      ref_lookup(if_pc, exp_hit, exp_target, exp_pred);
      check_bit("hit", hit, exp_hit);
      check_word("target_out", target_out, exp_target);
      check_bit("prediction", prediction, exp_pred);
      if (dir_valid) begin
        check_bit("hit", hit, dir_hit);
        check_word("target_out", target_out, dir_target);
        check_bit("prediction", prediction, dir_pred);
      end
    end
  end

  task automatic drive(input rv32i_word f_pc, input rv32i_word m_pc, input rv32i_word tgt,
                       input logic rep, input logic upd, input logic res);
    @(negedge clk);
    if_pc         <= f_pc;
    mem_pc        <= m_pc;
    target_in     <= tgt;
    replace       <= rep;
    update        <= upd;
    branch_result <= res;
    dir_valid     <= 1'b0;
  endtask

  task automatic drive_idle();
    drive(if_pc, mem_pc, '0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic install(input rv32i_word pc, input rv32i_word tgt);
    drive(pc, pc, tgt, 1'b1, 1'b0, 1'b0);
  endtask

  task automatic train(input rv32i_word pc, input logic taken);
    drive(pc, pc, '0, 1'b0, 1'b1, taken);
  endtask

  // looks up pc and expects the given outputs one edge later
  task automatic expect_lookup(input rv32i_word pc, input logic e_hit,
                               input rv32i_word e_target, input logic e_pred);
    drive(pc, pc, '0, 1'b0, 1'b0, 1'b0);
    dir_valid  <= 1'b1;
    dir_hit    <= e_hit;
    dir_target <= e_target;
    dir_pred   <= e_pred;
  endtask

  task automatic apply_reset();
    drive_idle();
    rst <= 1'b1;
    repeat (5) @(negedge clk);
    rst <= 1'b0;
  endtask

  task automatic start_test();
    test_err_base = error_count;
  endtask

  task automatic finish_test(input string name);
    drive_idle(); // last expectation is checked on this edge
    @(posedge clk);
    if (error_count == test_err_base) begin
      $display("test %s: passed", name);
    end else begin
      $display("test %s: failed with %0d errors", name, error_count - test_err_base);
    end
  endtask

  initial begin : stimulus
    rv32i_word pc_a;
    rv32i_word tgt_a;
    rv32i_word tgt_new;
    rv32i_word f_pc;
    rv32i_word m_pc;
    rv32i_word tgt;
    logic [31:0] rnd;
    rst           = 1'b1;
    if_pc         = '0;
    mem_pc        = '0;
    target_in     = '0;
    replace       = 1'b0;
    update        = 1'b0;
    branch_result = 1'b0;
    dir_valid     = 1'b0;
    dir_hit       = 1'b0;
    dir_target    = '0;
    dir_pred      = 1'b0;
    repeat (5) @(negedge clk);
    rst <= 1'b0;

    start_test();
    for (int i = 0; i < 8; i++) begin
      expect_lookup(pool_pc(random_index(POOL_SIZE)), 1'b0, '0, 1'b0);
    end
    finish_test("reset state");

    start_test();
    pc_a  = 32'h0000_0100;
    tgt_a = random_aligned();
    install(pc_a, tgt_a);
    expect_lookup(pc_a, 1'b1, tgt_a, 1'b0);
    expect_lookup(pc_a + 32'd4, 1'b0, '0, 1'b0);
    expect_lookup(pool_pc(0), 1'b0, '0, 1'b0);
    finish_test("install and look up");

    start_test();
    for (int i = 0; i < 8; i++) begin
      train(pc_a, TRAIN_OUTCOME[i]);
      expect_lookup(pc_a, 1'b1, tgt_a, TRAIN_PRED[i]);
    end
    for (int i = 0; i < 3; i++) begin
      train(pool_pc(5), 1'b1); // pc not in the buffer
    end
    expect_lookup(pc_a, 1'b1, tgt_a, 1'b0);
    expect_lookup(pool_pc(5), 1'b0, '0, 1'b0);
    finish_test("counter training");

    apply_reset();
    start_test();
    expect_lookup(pc_a, 1'b0, '0, 1'b0); // entry installed before the reset is gone
    finish_test("reset clears entries");

    start_test();
    for (int i = 0; i < `BTB_ENTRIES + 4; i++) begin
      fill_target[i] = random_aligned();
      install(pool_pc(i), fill_target[i]);
    end
    for (int i = 0; i < 4; i++) begin
      expect_lookup(pool_pc(i), 1'b0, '0, 1'b0); // oldest four were evicted
    end
    for (int i = 4; i < `BTB_ENTRIES + 4; i++) begin
      expect_lookup(pool_pc(i), 1'b1, fill_target[i], 1'b0);
    end
    finish_test("replacement");

    start_test();
    train(pool_pc(10), 1'b1);
    train(pool_pc(10), 1'b1);
    expect_lookup(pool_pc(10), 1'b1, fill_target[10], 1'b1);
    tgt_new = random_aligned();
    install(pool_pc(10), tgt_new);
    expect_lookup(pool_pc(10), 1'b1, tgt_new, 1'b0);
    fill_target[20] = random_aligned();
    install(pool_pc(20), fill_target[20]);
    // the pointer still sits on the entry of pool_pc(4)
    expect_lookup(pool_pc(4), 1'b0, '0, 1'b0);
    expect_lookup(pool_pc(5), 1'b1, fill_target[5], 1'b0);
    expect_lookup(pool_pc(20), 1'b1, fill_target[20], 1'b0);
    finish_test("reinstall in place");

    start_test();
    for (int i = 0; i < RANDOM_CYCLES; i++) begin
      rnd  = $random(seed);
      f_pc = pool_pc(random_index(POOL_SIZE));
      m_pc = pool_pc(random_index(POOL_SIZE));
      tgt  = random_aligned();
      drive(f_pc, m_pc, tgt, rnd[1:0] == 2'b00, rnd[2], rnd[3]);
    end
    finish_test("random mix");

    $display("summary: %0d checks passed, %0d errors", pass_count, error_count);
    if (error_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
